// ==== design/octaPkg.sv ====
// Octa core shared types
`default_nettype none

package octaPkg;

  typedef logic [7:0]  word_t;    // Data word
  typedef logic [15:0] instr_t;   // Instruction word
  typedef logic [2:0]  regIdx_t;  // Register index
  typedef logic [3:0]  pc_t;      // Program address

  // Opcodes in bits 2..0
  localparam logic [2:0] OpR = 3'b000;
  localparam logic [2:0] OpI = 3'b001;
  localparam logic [2:0] OpB = 3'b100;
  localparam logic [2:0] OpJ = 3'b101;

  // ALU functions in bits 5..3, shared by R and I groups
  localparam logic [2:0] FuncAdd  = 3'b000;
  localparam logic [2:0] FuncSub  = 3'b001;  // No I-type form
  localparam logic [2:0] FuncNand = 3'b010;
  localparam logic [2:0] FuncNor  = 3'b011;
  localparam logic [2:0] FuncSltu = 3'b100;
  localparam logic [2:0] FuncSll  = 3'b101;
  localparam logic [2:0] FuncSrl  = 3'b110;
  localparam logic [2:0] FuncSra  = 3'b111;

  // Branch functions
  localparam logic [2:0] FuncBeq  = 3'b000;
  localparam logic [2:0] FuncBne  = 3'b001;
  localparam logic [2:0] FuncBlt  = 3'b010;
  localparam logic [2:0] FuncBltu = 3'b011;
  localparam logic [2:0] FuncBge  = 3'b100;
  localparam logic [2:0] FuncBgeu = 3'b101;

  // Jump functions
  localparam logic [2:0] FuncJal  = 3'b000;
  localparam logic [2:0] FuncJalr = 3'b100;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluNand,
    AluNor,
    AluSltu,
    AluSll,
    AluSrl,
    AluSra
  } aluOp_t;

  typedef enum logic [2:0] {
    CondNone,
    CondEq,
    CondNe,
    CondLt,
    CondLtu,
    CondGe,
    CondGeu
  } branchCond_t;

  typedef struct packed {
    regIdx_t     rs1;
    regIdx_t     rs2;
    regIdx_t     rd;
    word_t       imm;
    aluOp_t      aluOp;
    logic        useImm;      // Operand B from immediate
    logic        usePcA;      // Operand A from pc
    logic        isBranch;
    logic        isJump;
    logic        writesReg;
    branchCond_t branchCond;
  } decoded_t;

  typedef struct packed {
    word_t aluValue;
    logic  taken;           // Branch condition holds
  } execResult_t;

  typedef struct packed {
    logic    valid;
    regIdx_t rd;
    word_t   data;
  } commit_t;

endpackage

`default_nettype wire

// ==== design/octaFetch.sv ====
// Program counter and program store
`default_nettype none

module octaFetch #(
  parameter int ProgDepth = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            programWrite,
  input  octaPkg::pc_t    programAddr,
  input  octaPkg::instr_t programData,
  input  octaPkg::pc_t    nextPc,
  output octaPkg::pc_t    pc,
  output octaPkg::instr_t instr
);

  octaPkg::instr_t progMem [ProgDepth];

  // External load port, addresses beyond the depth are dropped
  always_ff @(posedge clk) begin
    if (programWrite && (int'(programAddr) < ProgDepth)) begin
      progMem[programAddr] <= programData;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (programWrite) begin
      pc <= '0;  // Core held while loading
    end else if (int'(nextPc) < ProgDepth) begin
      pc <= nextPc;
    end else begin
      pc <= '0;  // Wrap at the end of the store
    end
  end

  assign instr = progMem[pc];  // Combinational fetch

endmodule

`default_nettype wire

// ==== design/octaDecode.sv ====
// Instruction decoder
`default_nettype none

module octaDecode (
  input  octaPkg::instr_t  instr,
  output octaPkg::decoded_t dec
);

  logic [2:0]           opcode;
  logic [2:0]           func;
  octaPkg::aluOp_t      aluFromFunc;
  octaPkg::branchCond_t condFromFunc;

  assign opcode = instr[2:0];
  assign func   = instr[5:3];

  always_comb begin
    case (func)
      octaPkg::FuncAdd:  aluFromFunc = octaPkg::AluAdd;
      octaPkg::FuncSub:  aluFromFunc = octaPkg::AluSub;
      octaPkg::FuncNand: aluFromFunc = octaPkg::AluNand;
      octaPkg::FuncNor:  aluFromFunc = octaPkg::AluNor;
      octaPkg::FuncSltu: aluFromFunc = octaPkg::AluSltu;
      octaPkg::FuncSll:  aluFromFunc = octaPkg::AluSll;
      octaPkg::FuncSrl:  aluFromFunc = octaPkg::AluSrl;
      default:           aluFromFunc = octaPkg::AluSra;
    endcase
  end

  always_comb begin
    case (func)
      octaPkg::FuncBeq:  condFromFunc = octaPkg::CondEq;
      octaPkg::FuncBne:  condFromFunc = octaPkg::CondNe;
      octaPkg::FuncBlt:  condFromFunc = octaPkg::CondLt;
      octaPkg::FuncBltu: condFromFunc = octaPkg::CondLtu;
      octaPkg::FuncBge:  condFromFunc = octaPkg::CondGe;
      octaPkg::FuncBgeu: condFromFunc = octaPkg::CondGeu;
      default:           condFromFunc = octaPkg::CondNone;
    endcase
  end

  always_comb begin
    dec            = '0;  // No-operation unless a group matches
    dec.rs1        = instr[11:9];
    dec.rs2        = instr[14:12];
    dec.rd         = instr[8:6];
    dec.aluOp      = octaPkg::AluAdd;
    dec.branchCond = octaPkg::CondNone;
    case (opcode)
      octaPkg::OpR: begin
        dec.aluOp     = aluFromFunc;
        dec.writesReg = 1'b1;
      end
      octaPkg::OpI: begin
        dec.imm       = {{5{instr[15]}}, instr[14:12]};
        dec.useImm    = 1'b1;
        dec.aluOp     = aluFromFunc;
        dec.writesReg = (func != octaPkg::FuncSub);  // SUBI does not exist
      end
      octaPkg::OpB: begin
        dec.imm        = {{5{instr[15]}}, instr[8:6]};
        dec.useImm     = 1'b1;
        dec.usePcA     = 1'b1;  // Target is pc plus offset
        dec.branchCond = condFromFunc;
        dec.isBranch   = (condFromFunc != octaPkg::CondNone);
      end
      octaPkg::OpJ: begin
        if (func == octaPkg::FuncJal) begin
          dec.imm       = {1'b0, instr[15:9]};
          dec.useImm    = 1'b1;
          dec.usePcA    = 1'b1;
          dec.isJump    = 1'b1;
          dec.writesReg = 1'b1;
        end else if (func == octaPkg::FuncJalr) begin
          dec.imm       = {instr[15:12], 4'b0000};  // Upper immediate
          dec.useImm    = 1'b1;
          dec.isJump    = 1'b1;
          dec.writesReg = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/octaRegFile.sv ====
// Eight-entry register file
`default_nettype none

module octaRegFile (
  input  logic             clk,
  input  logic             rst,
  input  octaPkg::regIdx_t rs1,
  input  octaPkg::regIdx_t rs2,
  input  octaPkg::regIdx_t rd,
  input  logic             writeEn,
  input  octaPkg::word_t   writeData,
  output octaPkg::word_t   rs1Value,
  output octaPkg::word_t   rs2Value
);

  octaPkg::word_t regs [8];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[rd] <= writeData;  // Strobe already excludes r0
    end
  end

  // Register 0 reads as zero
  assign rs1Value = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/octaExecute.sv ====
// Operand select, ALU and branch compare
`default_nettype none

module octaExecute (
  input  octaPkg::decoded_t    dec,
  input  octaPkg::pc_t         pc,
  input  octaPkg::word_t       rs1Value,
  input  octaPkg::word_t       rs2Value,
  output octaPkg::execResult_t result
);

  octaPkg::word_t opA;
  octaPkg::word_t opB;
  octaPkg::word_t aluValue;
  logic [15:0]    sraExt;
  logic [8:0]     diff;
  logic           borrow;
  logic           equal;
  logic           ltSigned;
  logic           taken;

  assign opA = dec.usePcA ? {4'b0000, pc} : rs1Value;
  assign opB = dec.useImm ? dec.imm : rs2Value;

  // Sign-extend to 16 bits so the shift pulls in copies of bit 7
  assign sraExt = {{8{opA[7]}}, opA} >> opB[2:0];

  always_comb begin
    case (dec.aluOp)
      octaPkg::AluAdd:  aluValue = opA + opB;
      octaPkg::AluSub:  aluValue = opA - opB;
      octaPkg::AluNand: aluValue = ~(opA & opB);
      octaPkg::AluNor:  aluValue = ~(opA | opB);
      octaPkg::AluSltu: aluValue = (opA < opB) ? 8'd1 : 8'd0;
      octaPkg::AluSll:  aluValue = opA << opB[2:0];
      octaPkg::AluSrl:  aluValue = opA >> opB[2:0];
      default:          aluValue = sraExt[7:0];
    endcase
  end

  // Branch compare always on the register values
  assign diff     = {1'b0, rs1Value} - {1'b0, rs2Value};
  assign borrow   = diff[8];  // Unsigned less-than
  assign equal    = (diff[7:0] == 8'd0);
  assign ltSigned = (rs1Value[7] ^ rs2Value[7]) ? rs1Value[7] : borrow;

  always_comb begin
    case (dec.branchCond)
      octaPkg::CondEq:  taken = equal;
      octaPkg::CondNe:  taken = !equal;
      octaPkg::CondLt:  taken = ltSigned;
      octaPkg::CondLtu: taken = borrow;
      octaPkg::CondGe:  taken = !ltSigned;
      octaPkg::CondGeu: taken = !borrow;
      default:          taken = 1'b0;
    endcase
  end

  assign result = '{aluValue: aluValue, taken: taken};

endmodule

`default_nettype wire

// ==== design/octaResult.sv ====
// Write-back and next pc
`default_nettype none

module octaResult (
  input  octaPkg::decoded_t    dec,
  input  octaPkg::execResult_t result,
  input  octaPkg::pc_t         pc,
  input  logic                 programWrite,
  output octaPkg::commit_t     commit,
  output octaPkg::pc_t         nextPc
);

  octaPkg::pc_t pcPlusOne;
  logic         redirect;

  assign pcPlusOne = pc + 4'd1;  // Wraps in four bits
  assign redirect  = dec.isJump || (dec.isBranch && result.taken);

  always_comb begin
    commit.valid = dec.writesReg && !programWrite && (dec.rd != '0);
    commit.rd    = dec.rd;
    // Jumps link the return address
    commit.data  = dec.isJump ? {4'b0000, pcPlusOne} : result.aluValue;
  end

  assign nextPc = redirect ? result.aluValue[3:0] : pcPlusOne;

endmodule

`default_nettype wire

// ==== design/octaTop.sv ====
// Octa single-cycle core
`default_nettype none

module octaTop #(
  parameter int ProgDepth = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             programWrite,
  input  octaPkg::pc_t     programAddr,
  input  octaPkg::instr_t  programData,
  output octaPkg::commit_t commit,
  output octaPkg::pc_t     pc
);

  octaPkg::instr_t      instr;
  octaPkg::pc_t         nextPc;
  octaPkg::decoded_t    dec;
  octaPkg::word_t       rs1Value;
  octaPkg::word_t       rs2Value;
  octaPkg::execResult_t result;

  octaFetch #(.ProgDepth(ProgDepth)) uFetch (
    .clk(clk), .rst(rst),
    .programWrite(programWrite), .programAddr(programAddr), .programData(programData),
    .nextPc(nextPc), .pc(pc), .instr(instr)
  );

  octaDecode uDecode (.instr(instr), .dec(dec));

  octaRegFile uRegFile (
    .clk(clk), .rst(rst),
    .rs1(dec.rs1), .rs2(dec.rs2),
    .rd(commit.rd), .writeEn(commit.valid), .writeData(commit.data),  // Commit drives write port
    .rs1Value(rs1Value), .rs2Value(rs2Value)
  );

  octaExecute uExecute (
    .dec(dec), .pc(pc),
    .rs1Value(rs1Value), .rs2Value(rs2Value),
    .result(result)
  );

  octaResult uResult (
    .dec(dec), .result(result), .pc(pc),
    .programWrite(programWrite),
    .commit(commit), .nextPc(nextPc)
  );

endmodule

`default_nettype wire

// ==== verification/octaTop_assertions.sv ====
// Octa core bound checks
`default_nettype none

module octaTopAssertions (
  input logic             clk,
  input logic             rst,
  input logic             programWrite,
  input octaPkg::commit_t commit,
  input octaPkg::pc_t     pc
);

  property pcClearedByReset;
    @(posedge clk) rst |=> (pc == '0);
  endproperty

  property pcHeldWhileLoading;
    @(posedge clk) programWrite |=> (pc == '0);  // Hold takes effect at the edge
  endproperty

  property noCommitWhenIdle;
    @(posedge clk) (rst || programWrite) |-> !commit.valid;
  endproperty

  property noCommitToZero;
    @(posedge clk) commit.valid |-> (commit.rd != '0);  // r0 is never written
  endproperty

  assert property (pcClearedByReset)
    else $error("pc is not zero after a cycle in reset");
  assert property (pcHeldWhileLoading)
    else $error("pc moved while the program was being loaded");
  assert property (noCommitWhenIdle)
    else $error("commit is valid during reset or loading");
  assert property (noCommitToZero)
    else $error("commit is valid with register 0 as destination");

endmodule

bind octaTop octaTopAssertions uAssertions (
  .clk(clk),
  .rst(rst),
  .programWrite(programWrite),
  .commit(commit),
  .pc(pc)
);

`default_nettype wire

// ==== include/octaTbProgram.svh ====
// Octa test program table
`ifndef OCTA_TB_PROGRAM_SVH
`define OCTA_TB_PROGRAM_SVH

typedef struct packed {
  octaPkg::instr_t  instr;
  logic             fill;    // Never executed, free for random bits
  logic             valid;
  octaPkg::regIdx_t rd;
  octaPkg::word_t   data;
  octaPkg::pc_t     nextPc;
} progRow_t;

localparam int TbProgLen  = 16;
localparam int TbTraceLen = 14;  // One pass plus the wrap back to 0

localparam progRow_t TbProgram [TbProgLen] = '{
  '{16'hD041, 1'b0, 1'b1, 3'd1, 8'hFD, 4'd1},   // ADDI r1, r0, -3
  '{16'h3081, 1'b0, 1'b1, 3'd2, 8'h03, 4'd2},   // ADDI r2, r0, 3
  '{16'h1201, 1'b0, 1'b0, 3'd0, 8'hFE, 4'd3},   // ADDI r0, r1, 1 suppressed
  '{16'h12F9, 1'b0, 1'b1, 3'd3, 8'hFE, 4'd4},   // SRAI r3, r1, 1
  '{16'h1508, 1'b0, 1'b1, 3'd4, 8'h06, 4'd5},   // SUB r4, r2, r1 wraps
  '{16'h1560, 1'b0, 1'b1, 3'd5, 8'h01, 4'd6},   // SLTU r5, r2, r1
  '{16'h23B8, 1'b0, 1'b1, 3'd6, 8'hFF, 4'd7},   // SRA r6, r1, r2
  '{16'h2294, 1'b0, 1'b0, 3'd2, 8'h09, 4'd9},   // BLT r1, r2, +2 taken
  '{16'h0000, 1'b1, 1'b0, 3'd0, 8'h00, 4'd0},   // Skipped
  '{16'h22DC, 1'b0, 1'b0, 3'd3, 8'h0C, 4'd10},  // BLTU r1, r2, +3 not taken
  '{16'h22AC, 1'b0, 1'b0, 3'd2, 8'h0C, 4'd12},  // BGEU r1, r2, +2 taken
  '{16'h0000, 1'b1, 1'b0, 3'd0, 8'h00, 4'd0},   // Skipped
  '{16'h05C5, 1'b0, 1'b1, 3'd7, 8'h0D, 4'd14},  // JAL r7, +2
  '{16'h0000, 1'b1, 1'b0, 3'd0, 8'h00, 4'd0},   // Skipped
  '{16'h1D65, 1'b0, 1'b1, 3'd5, 8'h0F, 4'd15},  // JALR r5, r6, 0x10
  '{16'h66C4, 1'b0, 1'b0, 3'd3, 8'h12, 4'd0}    // BEQ r3, r6, +3 not taken
};

`endif

// ==== verification/octaTb.sv ====
// Octa core testbench
`default_nettype none

module octaTb;

  `include "octaTbProgram.svh"

  localparam int ProgDepth  = 16;
  localparam int CycleLimit = 2 * (TbProgLen + TbTraceLen) + 20;

  logic             clk;
  logic             rst;
  logic             programWrite;
  octaPkg::pc_t     programAddr;
  octaPkg::instr_t  programData;
  octaPkg::commit_t commit;
  octaPkg::pc_t     pc;

  int cycleCount = 0;

  octaTop #(.ProgDepth(ProgDepth)) u_octaTop (
    .clk(clk),
    .rst(rst),
    .programWrite(programWrite),
    .programAddr(programAddr),
    .programData(programData),
    .commit(commit),
    .pc(pc)
  );

  always #4 clk = ~clk;  // Period of 8

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // Compares a commit, or only its valid bit when validOnly is set
  task automatic checkCommit(input octaPkg::commit_t actual, input octaPkg::commit_t expected,
                             input bit validOnly, input string what);
    bit mismatch;
    mismatch = validOnly ? (actual.valid !== expected.valid) : (actual !== expected);
    if (mismatch) begin
      $display("ERROR at %0t: %s commit got valid=%0b rd=%0d data=%h", $time, what,
               actual.valid, actual.rd, actual.data);
      $display("ERROR at %0t: %s commit expected valid=%0b rd=%0d data=%h", $time, what,
               expected.valid, expected.rd, expected.data);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first commit mismatch");
    end
  endtask

  task automatic checkPc(input octaPkg::pc_t actual, input octaPkg::pc_t expected,
                         input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s pc got %0d, expected %0d", $time, what, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first pc mismatch");
    end
  endtask

  initial begin
    wait (cycleCount >= CycleLimit);
    $display("ERRORS FOUND");
    $fatal(1, "Timeout: the program trace did not finish within %0d cycles", CycleLimit);
  end

  initial begin
    progRow_t         row;
    octaPkg::pc_t     expPc;
    octaPkg::commit_t expCommit;
    octaPkg::commit_t idleCommit;
    void'($urandom(62));
    clk          = 1'b0;
    rst          = 1'b1;
    programWrite = 1'b0;
    programAddr  = '0;
    programData  = '0;
    idleCommit   = '0;

    @(negedge clk);
    checkPc(pc, '0, "reset");
    @(negedge clk);

    // Reset released together with the first program word
    for (int i = 0; i < TbProgLen; i++) begin
      row          = TbProgram[i];
      rst          = 1'b0;
      programWrite = 1'b1;
      programAddr  = octaPkg::pc_t'(i);
      programData  = row.fill ? octaPkg::instr_t'($urandom) : row.instr;  // Filler is never run
      #1;
      checkPc(pc, '0, "loading");
      checkCommit(commit, idleCommit, 1'b1, "loading");
      @(negedge clk);
    end

    programWrite = 1'b0;
    programAddr  = '0;
    programData  = '0;
    expPc        = '0;

    // Follow the expected execution path through the table
    for (int step = 0; step < TbTraceLen; step++) begin
      row             = TbProgram[expPc];
      expCommit.valid = row.valid;
      expCommit.rd    = row.rd;
      expCommit.data  = row.data;
      #1;
      checkPc(pc, expPc, "trace");
      checkCommit(commit, expCommit, 1'b0, "trace");
      expPc = row.nextPc;
      @(negedge clk);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/octaPkg.sv
design/octaFetch.sv
design/octaDecode.sv
design/octaRegFile.sv
design/octaExecute.sv
design/octaResult.sv
design/octaTop.sv
verification/octaTop_assertions.sv
verification/octaTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the octa core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module octaTb \
  -f flist.f \
  -o octaSim

# A $fatal or a failed assertion gives a nonzero exit status
./obj_dir/octaSim
